/* sim.f */
source/hash_pkg.sv
source/mmio_pkg.sv
source/hash_cmd_if.sv
source/hash_reg_decode.sv
source/toeplitz_hash_acc.sv
source/hash_read_port.sv
source/hash_accel_top.sv
bench/tb_clock_gen.sv
bench/hash_accel_checker.sv
bench/hash_accel_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the hash accelerator testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

TOP=hash_accel_tb
BUILD_DIR=obj_dir
EXE=sim_top
LOG=sim.log

echo "Building $TOP with Verilator"
verilator --binary --timing --assert \
  -f sim.f \
  --top-module "$TOP" \
  -Mdir "$BUILD_DIR" \
  -o "$EXE"
status=$?
if [ "$status" -ne 0 ]; then
  echo "Build failed with status $status"
  exit 1
fi

echo "Running simulation, log in $LOG"
"./$BUILD_DIR/$EXE" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TESTBENCH PASSED" "$LOG"; then
  echo "Result: pass"
  exit 0
else
  echo "Result: fail"
  exit 1
fi

/* bench/hash_accel_tb.sv */
// RSS hash accelerator testbench: register traffic checked against a Toeplitz model.
`timescale 1ns/1ps
`default_nettype none

module hash_accel_tb;
  import hash_pkg::*;
  import mmio_pkg::*;

  localparam int CLK_PERIOD_NS = 4;
  localparam int RESET_CYCLES  = 4;
  localparam int MAX_REQUESTS  = 360;  // Bound on requests over all tests.
  localparam int WATCHDOG_NS   = (MAX_REQUESTS * 10 + RESET_CYCLES) * CLK_PERIOD_NS;
  localparam int REPLY_TIMEOUT = 4;
  localparam int MSG_MAX       = 64;
  localparam int KIND_HASH     = 0;
  localparam int KIND_COUNT    = 1;
  localparam int KIND_ZERO     = 2;
  localparam io_addr_t REG_BASE = 22'h2a_0000;  // Upper bits are not decoded.

  logic     clk;
  logic     rst;
  logic     io_en;
  logic     io_wen;
  io_strb_t io_strb;
  io_addr_t io_addr;
  io_data_t io_wr_data;
  io_data_t io_rd_data;
  logic     io_rd_valid;

  integer      seed = 32'h118ec5f3;
  logic [7:0]  msg_bytes [0:MSG_MAX-1];  // Bytes written since the last clear.
  int          msg_len = 0;
  byte_count_t exp_count = '0;
  int          exp_kind_q[$];
  io_data_t    exp_val_q[$];
  int          errors = 0;      // Protocol errors seen by the stimulus.
  int          cmp_errors = 0;  // Value mismatches.
  int          checks = 0;

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) u_clock (
    .clk (clk),
    .rst (rst)
  );

  hash_accel_top u_dut (
    .clk         (clk),
    .rst         (rst),
    .io_en       (io_en),
    .io_wen      (io_wen),
    .io_strb     (io_strb),
    .io_addr     (io_addr),
    .io_wr_data  (io_wr_data),
    .io_rd_data  (io_rd_data),
    .io_rd_valid (io_rd_valid)
  );

  bind hash_accel_top hash_accel_checker u_checker (
    .clk         (clk),
    .rst         (rst),
    .io_en       (io_en),
    .io_wen      (io_wen),
    .io_rd_valid (io_rd_valid),
    .clear       (cmd_if.clear),
    .hash        (hash)
  );

  // Bit i of the message selects key bits 319-i down to 288-i.
  function automatic hash_t toeplitz_ref(input int nbytes);
    hash_t h;
    int    i;
    int    n;
    h = '0;
    n = (nbytes < HASH_BYTES_DEFAULT) ? nbytes : HASH_BYTES_DEFAULT;
    for (int k = 0; k < n; k++) begin
      for (int b = 7; b >= 0; b--) begin
        i = k * 8 + (7 - b);
        if (msg_bytes[k][b]) begin
          h = h ^ HASH_KEY_DEFAULT[HASH_KEY_WIDTH-1-i -: HASH_WIDTH];
        end
      end
    end
    return h;
  endfunction

  function automatic io_data_t rand_word();
    return io_data_t'($random(seed));
  endfunction

  task automatic check_hash(input hash_t got, input hash_t exp);
    checks++;
    if (got !== exp) begin
      cmp_errors++;
      $display("ERR t=%0t io_rd_data(hash) got %08h expected %08h", $time, got, exp);
    end
  endtask

  task automatic check_count(input byte_count_t got, input byte_count_t exp);
    checks++;
    if (got !== exp) begin
      cmp_errors++;
      $display("ERR t=%0t io_rd_data(count) got %0d expected %0d", $time, got, exp);
    end
  endtask

  task automatic check_rd_data(input io_data_t got, input io_data_t exp, input string name);
    checks++;
    if (got !== exp) begin
      cmp_errors++;
      $display("ERR t=%0t %s got %08h expected %08h", $time, name, got, exp);
    end
  endtask

  task automatic bus_idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      io_en  = 1'b0;
      io_wen = 1'b0;
    end
  endtask

  task automatic write_reg(input reg_offset_t off, input io_data_t data);
    @(negedge clk);
    io_en      = 1'b1;
    io_wen     = 1'b1;
    io_addr    = REG_BASE | io_addr_t'(off);
    io_wr_data = data;
  endtask

  // Records the bytes, then writes them to the matching data register.
  task automatic write_data(input int nbytes, input io_data_t data);
    reg_offset_t off;
    case (nbytes)
      1:       off = REG_DATA1;
      2:       off = REG_DATA2;
      default: off = REG_DATA4;
    endcase
    for (int k = 0; k < nbytes; k++) begin
      if (msg_len < MSG_MAX) begin
        msg_bytes[msg_len] = data[8*k +: 8];
        msg_len++;
      end
      if (int'(exp_count) < HASH_BYTES_DEFAULT) begin
        exp_count = exp_count + byte_count_t'(1);  // Saturates at the key reach.
      end
    end
    write_reg(off, data);
  endtask

  task automatic clear_msg();
    write_reg(REG_CLEAR, rand_word());
    msg_len   = 0;
    exp_count = '0;
  endtask

  task automatic read_reg(input reg_offset_t off);
    int waited;
    @(negedge clk);
    io_en   = 1'b1;
    io_wen  = 1'b0;
    io_addr = REG_BASE | io_addr_t'(off);
    @(negedge clk);
    io_en  = 1'b0;
    waited = 0;
    while (!io_rd_valid && waited < REPLY_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!io_rd_valid) begin
      errors++;
      $display("Read of offset %03h at %0t got no reply", off, $time);
    end else if (waited != 0) begin
      errors++;
      $display("Read of offset %03h answered %0d cycles late", off, waited);
    end
  endtask

  task automatic read_expect(input reg_offset_t off, input int kind, input io_data_t exp);
    exp_kind_q.push_back(kind);
    exp_val_q.push_back(exp);
    read_reg(off);
  endtask

  // Reads hash and count once all writes have settled.
  task automatic check_state();
    bus_idle(2);
    read_expect(REG_HASH, KIND_HASH, io_data_t'(toeplitz_ref(msg_len)));
    read_expect(REG_COUNT, KIND_COUNT, io_data_t'(exp_count));
  endtask

  // Compares each read reply with the oldest pending expectation.
  always @(negedge clk) begin
    int       kind;
    io_data_t exp_val;
    if (!rst && io_rd_valid) begin
      if (exp_kind_q.size() == 0) begin
        cmp_errors++;
        $display("Read reply at %0t with no read pending", $time);
      end else begin
        kind    = exp_kind_q.pop_front();
        exp_val = exp_val_q.pop_front();
        case (kind)
          KIND_HASH: check_hash(io_rd_data, exp_val);
          KIND_COUNT: begin
            check_count(io_rd_data[7:0], exp_val[7:0]);
            check_rd_data(io_data_t'(io_rd_data[31:8]), '0, "io_rd_data[31:8]");
          end
          default: check_rd_data(io_rd_data, exp_val, "io_rd_data");
        endcase
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    int nwrites;
    int total;
    io_strb    = '1;
    io_en      = 1'b0;
    io_wen     = 1'b0;
    io_addr    = '0;
    io_wr_data = '0;
    @(negedge clk);
    while (rst !== 1'b0) @(negedge clk);

    check_state();  // Values out of reset.

    write_data(4, 32'h421e_09a1);  // Back-to-back writes of mixed length.
    write_data(2, 32'hdead_c0d7);
    write_data(1, 32'h0000_0080);
    write_data(4, 32'h6f31_00ff);
    write_data(1, 32'hffff_ff5c);
    write_data(2, 32'h0000_3b10);
    check_state();

    clear_msg();
    check_state();
    write_data(4, 32'h0102_0304);
    write_data(4, 32'hc0a8_0001);
    write_data(1, 32'h0000_0011);
    check_state();

    // Unmapped and write-only offsets read as zero, stray writes change nothing.
    read_expect(9'h000, KIND_ZERO, '0);
    read_expect(9'h118, KIND_ZERO, '0);
    read_expect(REG_CLEAR, KIND_ZERO, '0);
    read_expect(REG_DATA4, KIND_ZERO, '0);
    write_reg(9'h11C, rand_word());
    write_reg(9'h000, rand_word());
    write_reg(REG_HASH, rand_word());
    write_reg(REG_COUNT, rand_word());
    check_state();

    clear_msg();
    repeat (10) write_data(4, rand_word());  // 40 bytes, 36 hashed.
    check_state();

    for (int m = 0; m < 20; m++) begin
      nwrites = 1 + int'(rand_word() % 32'd10);
      for (int w = 0; w < nwrites; w++) begin
        case (int'(rand_word() % 32'd3))
          0:       write_data(1, rand_word());
          1:       write_data(2, rand_word());
          default: write_data(4, rand_word());
        endcase
      end
      check_state();
      clear_msg();
      check_state();
    end

    bus_idle(4);
    if (exp_kind_q.size() != 0) begin
      errors++;
      $display("%0d reads were never answered", exp_kind_q.size());
    end

    total = errors + cmp_errors + int'(u_dut.u_checker.assert_failures);
    $display("Checks: %0d, value errors: %0d, protocol errors: %0d, assertion failures: %0d",
             checks, cmp_errors, errors, u_dut.u_checker.assert_failures);
    if (total == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* bench/hash_accel_checker.sv */
// Hash accelerator checker: read reply timing and clear behavior, bound to the top level.
`timescale 1ns/1ps
`default_nettype none

module hash_accel_checker (
  input logic            clk,
  input logic            rst,
  input logic            io_en,
  input logic            io_wen,
  input logic            io_rd_valid,
  input logic            clear,
  input hash_pkg::hash_t hash
);
  import hash_pkg::*;

  int unsigned assert_failures = 0;
  logic        rd_req;

  assign rd_req = io_en && !io_wen;

  // Every read is answered on the next cycle.
  rd_reply_next: assert property (@(posedge clk) disable iff (rst)
    rd_req |=> io_rd_valid)
    else begin
      assert_failures++;
      $error("read request not answered on the next cycle");
    end

  // No reply without a read one cycle earlier.
  rd_reply_has_req: assert property (@(posedge clk) disable iff (rst)
    io_rd_valid |-> $past(rd_req))
    else begin
      assert_failures++;
      $error("read reply without a read request");
    end

  clear_zeroes_hash: assert property (@(posedge clk) disable iff (rst)
    clear |=> (hash == '0))
    else begin
      assert_failures++;
      $error("hash not zero one cycle after clear");
    end

endmodule

`default_nettype wire

/* bench/tb_clock_gen.sv */
// Testbench clock and reset source: free-running clock, reset held for the first cycles.
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst <= 1'b0;  // Released away from the active edge.
  end

endmodule

`default_nettype wire

/* source/hash_accel_top.sv */
// RSS hash accelerator top: register decode, Toeplitz hash and read port.
`timescale 1ns/1ps
`default_nettype none

module hash_accel_top #(
  parameter hash_pkg::hash_key_t HASH_KEY   = hash_pkg::HASH_KEY_DEFAULT,
  parameter int                  HASH_BYTES = hash_pkg::HASH_BYTES_DEFAULT
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               io_en,
  input  logic               io_wen,
  input  mmio_pkg::io_strb_t io_strb,     // Not used; all writes are full words.
  input  mmio_pkg::io_addr_t io_addr,
  input  mmio_pkg::io_data_t io_wr_data,
  output mmio_pkg::io_data_t io_rd_data,
  output logic               io_rd_valid
);
  import hash_pkg::*;

  hash_t       hash;
  byte_count_t byte_count;

  hash_cmd_if cmd_if ();

  hash_reg_decode u_decode (
    .clk        (clk),
    .rst        (rst),
    .io_en      (io_en),
    .io_wen     (io_wen),
    .io_addr    (io_addr),
    .io_wr_data (io_wr_data),
    .cmd        (cmd_if.src)
  );

  toeplitz_hash_acc #(
    .HASH_KEY   (HASH_KEY),
    .HASH_BYTES (HASH_BYTES)
  ) u_hash (
    .clk        (clk),
    .rst        (rst),
    .cmd        (cmd_if.dst),
    .hash       (hash),
    .byte_count (byte_count)
  );

  hash_read_port u_read (
    .clk         (clk),
    .rst         (rst),
    .io_en       (io_en),
    .io_wen      (io_wen),
    .io_addr     (io_addr),
    .hash        (hash),
    .byte_count  (byte_count),
    .io_rd_data  (io_rd_data),
    .io_rd_valid (io_rd_valid)
  );

endmodule

`default_nettype wire

/* source/hash_read_port.sv */
// Register read port: answers each host read with hash, byte count or zero.
`timescale 1ns/1ps
`default_nettype none

module hash_read_port (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  io_en,
  input  logic                  io_wen,
  input  mmio_pkg::io_addr_t    io_addr,
  input  hash_pkg::hash_t       hash,
  input  hash_pkg::byte_count_t byte_count,
  output mmio_pkg::io_data_t    io_rd_data,
  output logic                  io_rd_valid
);
  import mmio_pkg::*;

  reg_offset_t word_offset;
  logic        rd_req;

  assign word_offset = io_addr[REG_OFFSET_WIDTH-1:0] & ~reg_offset_t'(3);
  assign rd_req      = io_en && !io_wen;

  always_ff @(posedge clk) begin
    io_rd_valid <= rd_req;  // Every read gets one reply cycle.

    if (rd_req) begin
      case (word_offset)
        REG_HASH:  io_rd_data <= io_data_t'(hash);
        REG_COUNT: io_rd_data <= io_data_t'(byte_count);  // Zero extended.
        default:   io_rd_data <= '0;
      endcase
    end

    if (rst) begin
      io_rd_valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* source/toeplitz_hash_acc.sv */
// Toeplitz hash accumulator: folds up to four bytes per command into the hash.
`timescale 1ns/1ps
`default_nettype none

module toeplitz_hash_acc #(
  parameter hash_pkg::hash_key_t HASH_KEY   = hash_pkg::HASH_KEY_DEFAULT,
  parameter int                  HASH_BYTES = hash_pkg::HASH_BYTES_DEFAULT
) (
  input  logic                  clk,
  input  logic                  rst,
  hash_cmd_if.dst               cmd,
  output hash_pkg::hash_t       hash,
  output hash_pkg::byte_count_t byte_count
);
  import hash_pkg::*;

  hash_t       hash_next;
  byte_count_t count_next;

  // 32-bit key window starting at global bit index bit_idx.
  function automatic hash_t key_window(input int bit_idx);
    hash_key_t shifted;
    shifted = HASH_KEY << bit_idx;
    return shifted[HASH_KEY_WIDTH-1 -: HASH_WIDTH];
  endfunction

  function automatic int len_bytes(input hash_len_t len);
    int n;
    case (len)
      LEN_1B:  n = 1;
      LEN_2B:  n = 2;
      default: n = 4;  // Code 0, and the unused code 3.
    endcase
    return n;
  endfunction

  // Byte offset equals byte_count, as the count only moves on hashed bytes.
  always_comb begin
    int nbytes;
    int pos;
    hash_next  = hash;
    count_next = byte_count;
    nbytes     = len_bytes(cmd.len);
    for (int k = 0; k < 4; k++) begin
      pos = int'(byte_count) + k;
      if (k < nbytes && pos < HASH_BYTES) begin
        // Most significant bit of the byte first.
        for (int b = 0; b < 8; b++) begin
          if (cmd.data[8*k + 7 - b]) begin
            hash_next = hash_next ^ key_window(pos*8 + b);
          end
        end
        count_next = count_next + byte_count_t'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      hash       <= '0;
      byte_count <= '0;
    end else if (cmd.clear) begin
      hash       <= '0;  // Start of a new message.
      byte_count <= '0;
    end else if (cmd.valid) begin
      hash       <= hash_next;
      byte_count <= count_next;  // Stops at HASH_BYTES.
    end
  end

endmodule

`default_nettype wire

/* source/hash_reg_decode.sv */
// Register write decoder: turns host writes into one-cycle clear or data commands.
`timescale 1ns/1ps
`default_nettype none

module hash_reg_decode (
  input  logic               clk,
  input  logic               rst,
  input  logic               io_en,
  input  logic               io_wen,
  input  mmio_pkg::io_addr_t io_addr,
  input  mmio_pkg::io_data_t io_wr_data,
  hash_cmd_if.src            cmd
);
  import mmio_pkg::*;
  import hash_pkg::*;

  reg_offset_t word_offset;
  logic        wr_req;

  // Drop the byte lane bits.
  assign word_offset = io_addr[REG_OFFSET_WIDTH-1:0] & ~reg_offset_t'(3);
  assign wr_req      = io_en && io_wen;

  always_ff @(posedge clk) begin
    cmd.valid <= 1'b0;  // Strobes last one cycle.
    cmd.clear <= 1'b0;

    if (wr_req) begin
      case (word_offset)
        REG_CLEAR: begin
          cmd.clear <= 1'b1;
        end
        REG_DATA1: begin
          cmd.data  <= hash_data_t'(io_wr_data);
          cmd.len   <= LEN_1B;
          cmd.valid <= 1'b1;
        end
        REG_DATA2: begin
          cmd.data  <= hash_data_t'(io_wr_data);
          cmd.len   <= LEN_2B;
          cmd.valid <= 1'b1;
        end
        REG_DATA4: begin
          cmd.data  <= hash_data_t'(io_wr_data);
          cmd.len   <= LEN_4B;
          cmd.valid <= 1'b1;
        end
        default: ;  // Unmapped write.
      endcase
    end

    if (rst) begin
      cmd.valid <= 1'b0;
      cmd.clear <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* source/hash_cmd_if.sv */
// Hash command channel: clear and data strobes from the register decoder to the hash.
`timescale 1ns/1ps
`default_nettype none

interface hash_cmd_if;
  import hash_pkg::*;

  hash_data_t data;   // Valid only with valid.
  hash_len_t  len;
  logic       valid;  // One-cycle data strobe.
  logic       clear;  // One-cycle clear strobe.

  modport src (
    output data, len, valid, clear
  );

  modport dst (
    input data, len, valid, clear
  );

endinterface

`default_nettype wire

/* source/mmio_pkg.sv */
// Register port package: bus widths and the register map of the accelerator.
`default_nettype none

package mmio_pkg;

  localparam int IO_ADDR_WIDTH = 22;
  localparam int IO_DATA_WIDTH = 32;
  localparam int IO_STRB_WIDTH = IO_DATA_WIDTH / 8;

  typedef logic [IO_ADDR_WIDTH-1:0] io_addr_t;
  typedef logic [IO_DATA_WIDTH-1:0] io_data_t;
  typedef logic [IO_STRB_WIDTH-1:0] io_strb_t;

  // Register offsets live in the low address bits.
  localparam int REG_OFFSET_WIDTH = 9;
  typedef logic [REG_OFFSET_WIDTH-1:0] reg_offset_t;

  localparam reg_offset_t REG_CLEAR = 9'h100;
  localparam reg_offset_t REG_DATA1 = 9'h104;  // One byte.
  localparam reg_offset_t REG_DATA2 = 9'h108;  // Two bytes.
  localparam reg_offset_t REG_DATA4 = 9'h10C;  // Four bytes.
  localparam reg_offset_t REG_HASH  = 9'h110;
  localparam reg_offset_t REG_COUNT = 9'h114;

endpackage

`default_nettype wire

/* source/hash_pkg.sv */
// Hash datapath package: key, hash and word types plus the default Toeplitz key.
`default_nettype none

package hash_pkg;

  localparam int HASH_KEY_WIDTH  = 320;
  localparam int HASH_WIDTH      = 32;
  localparam int HASH_DATA_WIDTH = 32;

  typedef logic [HASH_KEY_WIDTH-1:0]  hash_key_t;
  typedef logic [HASH_WIDTH-1:0]      hash_t;
  typedef logic [HASH_DATA_WIDTH-1:0] hash_data_t;  // Byte 0 in bits 7:0.
  typedef logic [1:0]                 hash_len_t;
  typedef logic [7:0]                 byte_count_t;

  // Length codes of a data command.
  localparam hash_len_t LEN_4B = 2'd0;
  localparam hash_len_t LEN_1B = 2'd1;
  localparam hash_len_t LEN_2B = 2'd2;

  // Standard RSS key.
  localparam hash_key_t HASH_KEY_DEFAULT = {
    160'h6d5a56da255b0ec24167253d43a38fb0d0ca2bcb,
    160'hae7b30b477cb2da38030f20c6a42b73bbeac01fa
  };

  // Bytes whose full 32-bit key window fits in the key.
  localparam int HASH_BYTES_DEFAULT = 36;

endpackage

`default_nettype wire
